/* design/core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

////////////////////
// core dimensions
////////////////////

// register and datapath width
`define CORE_XLEN 32

// instruction queue entries, also the producer's starting credits
`define CORE_QUEUE_DEPTH 4

// retire credits held right after reset
`define CORE_RETIRE_CREDITS 2

`endif

/* design/core_pkg.sv */
`include "core_settings.svh"

package core_pkg;

	typedef logic [`CORE_XLEN-1:0] word_t;

	////////////////////
	// major opcodes
	////////////////////
	typedef enum logic [6:0] {
		OP_R   = 7'b0110011,
		OP_I   = 7'b0010011,
		OP_IL  = 7'b0000011,
		OP_S   = 7'b0100011,
		OP_B   = 7'b1100011,
		OP_U   = 7'b0110111,
		OP_UPC = 7'b0010111,
		OP_J   = 7'b1101111,
		OP_JR  = 7'b1100111,
		OP_SYS = 7'b1110011
	} opcode_e;

	// alu operation select
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B
	} alu_op_e;

	// branch condition, encoded as the funct3 value
	typedef enum logic [2:0] {
		BR_EQ   = 3'b000,
		BR_NE   = 3'b001,
		BR_NONE = 3'b010,
		BR_LT   = 3'b100,
		BR_GE   = 3'b101,
		BR_LTU  = 3'b110,
		BR_GEU  = 3'b111
	} br_cond_e;

endpackage

/* design/inst_queue.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module inst_queue (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  in_valid,
	input  logic [`CORE_XLEN-1:0] in_pc,
	input  logic [31:0]           in_inst,
	input  logic                  pop,
	output logic                  head_valid,
	output logic [`CORE_XLEN-1:0] head_pc,
	output logic [31:0]           head_inst,
	output logic                  in_credit
);

	localparam int DEPTH = `CORE_QUEUE_DEPTH;
	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	logic [`CORE_XLEN-1:0] pc_mem [DEPTH];
	logic [31:0] inst_mem [DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic full;
	logic push;

	// wrap for depths that are not a power of two
	function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
		return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full = (count == CW'(DEPTH));
	assign push = in_valid && !full;

	assign head_valid = (count != '0);
	assign head_pc = pc_mem[rd_ptr];
	assign head_inst = inst_mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			pc_mem[wr_ptr] <= in_pc;
			inst_mem[wr_ptr] <= in_inst;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			in_credit <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			count <= count + CW'(push) - CW'(pop);
			// one credit back per freed slot
			in_credit <= pop;
		end
	end

	// producer must hold a credit for every push
	no_push_full: assert property (@(posedge clk) disable iff (rst) !(in_valid && full));
	no_pop_empty: assert property (@(posedge clk) disable iff (rst) !(pop && !head_valid));

endmodule

/* design/idu.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module idu (
	input  logic [31:0]           inst,
	output core_pkg::opcode_e     opcode,
	output logic [4:0]            rd,
	output logic [4:0]            rs1,
	output logic [4:0]            rs2,
	output logic [`CORE_XLEN-1:0] imm,
	output logic [1:0]            ren,
	output core_pkg::alu_op_e     alu_op,
	output core_pkg::br_cond_e    br_cond,
	output logic                  use_imm,
	output logic                  illegal
);

	import core_pkg::*;

	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [`CORE_XLEN-1:0] imm_i;
	logic [`CORE_XLEN-1:0] imm_s;
	logic [`CORE_XLEN-1:0] imm_b;
	logic [`CORE_XLEN-1:0] imm_u;
	logic [`CORE_XLEN-1:0] imm_j;

	assign opcode = opcode_e'(inst[6:0]);
	assign rd = inst[11:7];
	assign rs1 = inst[19:15];
	assign rs2 = inst[24:20];
	assign funct7 = inst[31:25];

	// auipc and jal carry immediate bits in the funct3 slot
	always_comb begin
		case (opcode)
			OP_UPC, OP_J: funct3 = 3'b000;
			default:      funct3 = inst[14:12];
		endcase
	end

	////////////////////
	// immediates
	////////////////////
	assign imm_i = {{(`CORE_XLEN-12){inst[31]}}, inst[31:20]};
	assign imm_s = {{(`CORE_XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{(`CORE_XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {{(`CORE_XLEN-31){inst[31]}}, inst[30:12], 12'b0};
	assign imm_j = {{(`CORE_XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		case (opcode)
			OP_I, OP_IL, OP_JR: imm = imm_i;
			OP_S:               imm = imm_s;
			OP_B:               imm = imm_b;
			OP_U, OP_UPC:       imm = imm_u;
			OP_J:               imm = imm_j;
			default:            imm = '0;
		endcase
	end

	// bit 0 reads rs1, bit 1 reads rs2
	always_comb begin
		case (opcode)
			OP_R, OP_S, OP_B:   ren = 2'b11;
			OP_I, OP_IL, OP_JR: ren = 2'b01;
			default:            ren = 2'b00;
		endcase
	end

	////////////////////
	// operation select
	////////////////////
	always_comb begin
		alu_op = ALU_ADD;
		br_cond = BR_NONE;
		use_imm = 1'b0;
		illegal = 1'b0;
		case (opcode)
			OP_R: begin
				case ({funct7, funct3})
					{7'b0000000, 3'b000}: alu_op = ALU_ADD;
					{7'b0100000, 3'b000}: alu_op = ALU_SUB;
					{7'b0000000, 3'b001}: alu_op = ALU_SLL;
					{7'b0000000, 3'b010}: alu_op = ALU_SLT;
					{7'b0000000, 3'b011}: alu_op = ALU_SLTU;
					{7'b0000000, 3'b100}: alu_op = ALU_XOR;
					{7'b0000000, 3'b101}: alu_op = ALU_SRL;
					{7'b0100000, 3'b101}: alu_op = ALU_SRA;
					{7'b0000000, 3'b110}: alu_op = ALU_OR;
					{7'b0000000, 3'b111}: alu_op = ALU_AND;
					default:              illegal = 1'b1;
				endcase
			end
			OP_I: begin
				use_imm = 1'b1;
				case (funct3)
					3'b000: alu_op = ALU_ADD;
					3'b010: alu_op = ALU_SLT;
					3'b011: alu_op = ALU_SLTU;
					3'b100: alu_op = ALU_XOR;
					3'b110: alu_op = ALU_OR;
					3'b111: alu_op = ALU_AND;
					3'b001: begin
						alu_op = ALU_SLL;
						illegal = (funct7 != 7'b0000000);
					end
					default: begin
						// shift right, funct7 picks logical or arithmetic
						alu_op = (funct7 == 7'b0100000) ? ALU_SRA : ALU_SRL;
						illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
					end
				endcase
			end
			OP_B: begin
				case (funct3)
					3'b000:  br_cond = BR_EQ;
					3'b001:  br_cond = BR_NE;
					3'b100:  br_cond = BR_LT;
					3'b101:  br_cond = BR_GE;
					3'b110:  br_cond = BR_LTU;
					3'b111:  br_cond = BR_GEU;
					default: illegal = 1'b1;
				endcase
			end
			OP_U: begin
				use_imm = 1'b1;
				alu_op = ALU_PASS_B;
			end
			OP_UPC, OP_J: use_imm = 1'b1;
			OP_JR: begin
				use_imm = 1'b1;
				illegal = (funct3 != 3'b000);
			end
			// only ebreak is supported here
			OP_SYS:  illegal = (inst != 32'h0010_0073);
			default: illegal = 1'b1;
		endcase
	end

endmodule

/* design/gpr.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module gpr (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [4:0]            raddr1,
	input  logic [4:0]            raddr2,
	input  logic [1:0]            ren,
	input  logic                  we,
	input  logic [4:0]            waddr,
	input  logic [`CORE_XLEN-1:0] wdata,
	output logic [`CORE_XLEN-1:0] rdata1,
	output logic [`CORE_XLEN-1:0] rdata2
);

	logic [`CORE_XLEN-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && (waddr != 5'd0)) begin
			regs[waddr] <= wdata;
		end
	end

	// x0 and disabled ports read as zero
	assign rdata1 = (ren[0] && (raddr1 != 5'd0)) ? regs[raddr1] : '0;
	assign rdata2 = (ren[1] && (raddr2 != 5'd0)) ? regs[raddr2] : '0;

endmodule

/* design/exu.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module exu (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  head_valid,
	input  logic [`CORE_XLEN-1:0] head_pc,
	input  core_pkg::opcode_e     opcode,
	input  logic [4:0]            rd,
	input  logic [`CORE_XLEN-1:0] imm,
	input  core_pkg::alu_op_e     alu_op,
	input  core_pkg::br_cond_e    br_cond,
	input  logic                  use_imm,
	input  logic                  illegal,
	input  logic [`CORE_XLEN-1:0] rdata1,
	input  logic [`CORE_XLEN-1:0] rdata2,
	input  logic                  out_credit,
	output logic                  issue,
	output logic                  we,
	output logic [4:0]            waddr,
	output logic [`CORE_XLEN-1:0] wdata,
	output logic                  ret_valid,
	output logic [`CORE_XLEN-1:0] ret_pc,
	output logic [`CORE_XLEN-1:0] ret_next_pc,
	output logic [4:0]            ret_rd,
	output logic [`CORE_XLEN-1:0] ret_wdata,
	output logic                  ret_we,
	output logic                  ret_halt,
	output logic                  ret_illegal
);

	import core_pkg::*;

	// one spare count above the limit so an overflow is visible
	localparam int CW = $clog2(`CORE_RETIRE_CREDITS + 2);

	logic [CW-1:0] credit_cnt;
	logic halted;
	word_t alu_b;
	word_t alu_res;
	word_t pc_plus4;
	word_t pc_plus_imm;
	word_t jalr_target;
	word_t next_pc;
	logic [4:0] shamt;
	logic br_taken;
	logic writes_rd;
	logic is_halt;

	assign issue = head_valid && (credit_cnt != '0) && !halted;

	////////////////////
	// alu
	////////////////////
	assign alu_b = use_imm ? imm : rdata2;
	assign shamt = alu_b[4:0];

	always_comb begin
		case (alu_op)
			ALU_ADD:  alu_res = rdata1 + alu_b;
			ALU_SUB:  alu_res = rdata1 - alu_b;
			ALU_SLL:  alu_res = rdata1 << shamt;
			ALU_SLT:  alu_res = word_t'($signed(rdata1) < $signed(alu_b));
			ALU_SLTU: alu_res = word_t'(rdata1 < alu_b);
			ALU_XOR:  alu_res = rdata1 ^ alu_b;
			ALU_SRL:  alu_res = rdata1 >> shamt;
			ALU_SRA:  alu_res = $signed(rdata1) >>> shamt;
			ALU_OR:   alu_res = rdata1 | alu_b;
			ALU_AND:  alu_res = rdata1 & alu_b;
			default:  alu_res = alu_b;
		endcase
	end

	// branch compare
	always_comb begin
		case (br_cond)
			BR_EQ:   br_taken = (rdata1 == rdata2);
			BR_NE:   br_taken = (rdata1 != rdata2);
			BR_LT:   br_taken = ($signed(rdata1) < $signed(rdata2));
			BR_GE:   br_taken = ($signed(rdata1) >= $signed(rdata2));
			BR_LTU:  br_taken = (rdata1 < rdata2);
			BR_GEU:  br_taken = (rdata1 >= rdata2);
			default: br_taken = 1'b0;
		endcase
	end

	////////////////////
	// result and next pc
	////////////////////
	assign pc_plus4 = head_pc + word_t'(4);
	assign pc_plus_imm = head_pc + imm;
	assign jalr_target = (rdata1 + imm) & ~word_t'(1);

	always_comb begin
		wdata = alu_res;
		next_pc = pc_plus4;
		writes_rd = 1'b0;
		case (opcode)
			OP_R, OP_I, OP_U: writes_rd = 1'b1;
			OP_UPC: begin
				writes_rd = 1'b1;
				wdata = pc_plus_imm;
			end
			OP_J: begin
				writes_rd = 1'b1;
				wdata = pc_plus4;
				next_pc = pc_plus_imm;
			end
			OP_JR: begin
				writes_rd = 1'b1;
				wdata = pc_plus4;
				next_pc = jalr_target;
			end
			OP_B:    next_pc = br_taken ? pc_plus_imm : pc_plus4;
			default: writes_rd = 1'b0;
		endcase
		if (illegal)
			next_pc = pc_plus4;
	end

	// x0 writes never reach the register file
	assign we = issue && writes_rd && !illegal && (rd != 5'd0);
	assign waddr = rd;
	assign is_halt = (opcode == OP_SYS) && !illegal;

	always_ff @(posedge clk) begin
		if (rst) begin
			credit_cnt <= CW'(`CORE_RETIRE_CREDITS);
			halted <= 1'b0;
			ret_valid <= 1'b0;
		end else begin
			credit_cnt <= credit_cnt - CW'(issue) + CW'(out_credit);
			if (issue && is_halt)
				halted <= 1'b1;
			ret_valid <= issue;
		end
	end

	// retire record, captured only on issue
	always_ff @(posedge clk) begin
		if (issue) begin
			ret_pc <= head_pc;
			ret_next_pc <= next_pc;
			ret_rd <= rd;
			ret_wdata <= wdata;
			ret_we <= we;
			ret_halt <= is_halt;
			ret_illegal <= illegal;
		end
	end

	// consumer never returns more than it was given
	credit_bound: assert property (@(posedge clk) disable iff (rst)
		credit_cnt <= CW'(`CORE_RETIRE_CREDITS));

endmodule

/* design/core_top.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module core_top (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  in_valid,
	input  logic [`CORE_XLEN-1:0] in_pc,
	input  logic [31:0]           in_inst,
	output logic                  in_credit,
	output logic                  ret_valid,
	output logic [`CORE_XLEN-1:0] ret_pc,
	output logic [`CORE_XLEN-1:0] ret_next_pc,
	output logic [4:0]            ret_rd,
	output logic [`CORE_XLEN-1:0] ret_wdata,
	output logic                  ret_we,
	output logic                  ret_halt,
	output logic                  ret_illegal,
	input  logic                  out_credit
);

	import core_pkg::*;

	// queue head
	logic head_valid;
	logic [`CORE_XLEN-1:0] head_pc;
	logic [31:0] head_inst;
	logic issue;

	// decode
	opcode_e opcode;
	logic [4:0] rd;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [`CORE_XLEN-1:0] imm;
	logic [1:0] ren;
	alu_op_e alu_op;
	br_cond_e br_cond;
	logic use_imm;
	logic illegal;

	// register file
	logic [`CORE_XLEN-1:0] rdata1;
	logic [`CORE_XLEN-1:0] rdata2;
	logic we;
	logic [4:0] waddr;
	logic [`CORE_XLEN-1:0] wdata;

	////////////////////
	// instances
	////////////////////
	inst_queue u_queue (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.in_pc      (in_pc),
		.in_inst    (in_inst),
		.pop        (issue),
		.head_valid (head_valid),
		.head_pc    (head_pc),
		.head_inst  (head_inst),
		.in_credit  (in_credit)
	);

	idu u_idu (
		.inst    (head_inst),
		.opcode  (opcode),
		.rd      (rd),
		.rs1     (rs1),
		.rs2     (rs2),
		.imm     (imm),
		.ren     (ren),
		.alu_op  (alu_op),
		.br_cond (br_cond),
		.use_imm (use_imm),
		.illegal (illegal)
	);

	gpr u_gpr (
		.clk    (clk),
		.rst    (rst),
		.raddr1 (rs1),
		.raddr2 (rs2),
		.ren    (ren),
		.we     (we),
		.waddr  (waddr),
		.wdata  (wdata),
		.rdata1 (rdata1),
		.rdata2 (rdata2)
	);

	exu u_exu (
		.clk         (clk),
		.rst         (rst),
		.head_valid  (head_valid),
		.head_pc     (head_pc),
		.opcode      (opcode),
		.rd          (rd),
		.imm         (imm),
		.alu_op      (alu_op),
		.br_cond     (br_cond),
		.use_imm     (use_imm),
		.illegal     (illegal),
		.rdata1      (rdata1),
		.rdata2      (rdata2),
		.out_credit  (out_credit),
		.issue       (issue),
		.we          (we),
		.waddr       (waddr),
		.wdata       (wdata),
		.ret_valid   (ret_valid),
		.ret_pc      (ret_pc),
		.ret_next_pc (ret_next_pc),
		.ret_rd      (ret_rd),
		.ret_wdata   (ret_wdata),
		.ret_we      (ret_we),
		.ret_halt    (ret_halt),
		.ret_illegal (ret_illegal)
	);

endmodule

/* tests/tb_core.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module tb_core;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] next_pc;
		logic [31:0] wdata;
		logic [4:0]  rd;
		logic        we;
		logic        halt;
		logic        illegal;
	} ret_rec_t;

	logic clk;
	logic rst;
	logic in_valid;
	logic [`CORE_XLEN-1:0] in_pc;
	logic [31:0] in_inst;
	logic in_credit;
	logic ret_valid;
	logic [`CORE_XLEN-1:0] ret_pc;
	logic [`CORE_XLEN-1:0] ret_next_pc;
	logic [4:0] ret_rd;
	logic [`CORE_XLEN-1:0] ret_wdata;
	logic ret_we;
	logic ret_halt;
	logic ret_illegal;
	logic out_credit;

	integer seed = 95629;
	logic [31:0] mregs [32];
	logic [31:0] pend_pc [$];
	logic [31:0] pend_inst [$];
	ret_rec_t exp_q [$];
	logic [31:0] pc_gen;
	int errors, checks, tests, err_mark, check_mark;
	int prod_credits, owed, retired, returned, credit_pulses, pushes;
	int push_thresh, ret_thresh;

	core_top dut0 (
		.clk         (clk),
		.rst         (rst),
		.in_valid    (in_valid),
		.in_pc       (in_pc),
		.in_inst     (in_inst),
		.in_credit   (in_credit),
		.ret_valid   (ret_valid),
		.ret_pc      (ret_pc),
		.ret_next_pc (ret_next_pc),
		.ret_rd      (ret_rd),
		.ret_wdata   (ret_wdata),
		.ret_we      (ret_we),
		.ret_halt    (ret_halt),
		.ret_illegal (ret_illegal),
		.out_credit  (out_credit)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] rnd();
		return $random(seed);
	endfunction

	////////////////////
	// reference model
	////////////////////
	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		logic signed [31:0] sa;
		logic signed [31:0] sb;
		sa = a;
		sb = b;
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, sa < sb};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: begin
				if (alt)
					return sa >>> b[4:0];
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b);
		logic signed [31:0] sa;
		logic signed [31:0] sb;
		sa = a;
		sb = b;
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return sa < sb;
			3'd5: return sa >= sb;
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	// builds the expected retire record and updates the model registers
	task automatic expect_inst(input logic [31:0] pc, input logic [31:0] inst);
		ret_rec_t e;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_b;
		logic [31:0] imm_j;
		a = mregs[inst[19:15]];
		b = mregs[inst[24:20]];
		imm_i = {{20{inst[31]}}, inst[31:20]};
		imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
		imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
		e = '0;
		e.pc = pc;
		e.next_pc = pc + 32'd4;
		e.rd = inst[11:7];
		case (inst[6:0])
			7'h33: begin
				e.we = 1'b1;
				e.wdata = alu_ref(inst[14:12], inst[30], a, b);
			end
			7'h13: begin
				e.we = 1'b1;
				e.wdata = alu_ref(inst[14:12], inst[30] && (inst[14:12] == 3'd5), a, imm_i);
			end
			7'h37: begin
				e.we = 1'b1;
				e.wdata = {inst[31:12], 12'h000};
			end
			7'h17: begin
				e.we = 1'b1;
				e.wdata = pc + {inst[31:12], 12'h000};
			end
			7'h6f: begin
				e.we = 1'b1;
				e.wdata = pc + 32'd4;
				e.next_pc = pc + imm_j;
			end
			7'h67: begin
				e.we = 1'b1;
				e.wdata = pc + 32'd4;
				e.next_pc = (a + imm_i) & 32'hffff_fffe;
			end
			7'h63: begin
				if (branch_ref(inst[14:12], a, b))
					e.next_pc = pc + imm_b;
			end
			7'h73: begin
				if (inst == 32'h0010_0073)
					e.halt = 1'b1;
				else
					e.illegal = 1'b1;
			end
			default: e.illegal = 1'b1;
		endcase
		if (e.rd == 5'd0)
			e.we = 1'b0;
		if (e.we)
			mregs[e.rd] = e.wdata;
		exp_q.push_back(e);
	endtask

	////////////////////
	// stimulus
	////////////////////
	function automatic logic [31:0] gen_alu();
		logic [31:0] r;
		logic [2:0] f3;
		logic [6:0] f7;
		r = rnd();
		f3 = r[14:12];
		if (r[0]) begin
			f7 = ((f3 == 3'd0 || f3 == 3'd5) && r[30]) ? 7'h20 : 7'h00;
			return {f7, r[24:15], f3, r[11:7], 7'h33};
		end
		if (f3 == 3'd1)
			f7 = 7'h00;
		else if (f3 == 3'd5)
			f7 = {1'b0, r[30], 5'b0};
		else
			f7 = r[31:25];
		return {f7, r[24:15], f3, r[11:7], 7'h13};
	endfunction

	function automatic logic [31:0] gen_upper_jump();
		logic [31:0] r;
		logic [31:0] s;
		r = rnd();
		s = rnd();
		case (s[1:0])
			2'd0: return {r[31:12], r[11:7], 7'h37};
			2'd1: return {r[31:12], r[11:7], 7'h17};
			2'd2: return {r[31:12], r[11:7], 7'h6f};
			default: return {r[31:20], r[19:15], 3'b000, r[11:7], 7'h67};
		endcase
	endfunction

	function automatic logic [31:0] gen_branch();
		logic [31:0] r;
		logic [31:0] sel;
		logic [2:0] f3;
		logic [4:0] rs2;
		r = rnd();
		sel = rnd() % 32'd6;
		f3 = (sel < 32'd2) ? sel[2:0] : sel[2:0] + 3'd2;
		// same register on both sides now and then, so equal operands show up
		rs2 = r[0] ? r[19:15] : r[24:20];
		return {r[31:25], rs2, r[19:15], f3, r[11:7], 7'h63};
	endfunction

	function automatic logic [31:0] enc_add(input logic [4:0] rd, input logic [4:0] rs1,
			input logic [4:0] rs2);
		return {7'h00, rs2, rs1, 3'b000, rd, 7'h33};
	endfunction

	task automatic push_only(input logic [31:0] inst);
		pend_pc.push_back(pc_gen);
		pend_inst.push_back(inst);
		pc_gen = pc_gen + 32'd4;
	endtask

	task automatic add_inst(input logic [31:0] inst);
		expect_inst(pc_gen, inst);
		push_only(inst);
	endtask

	// copy every register onto itself so its value shows on ret_wdata
	task automatic readback();
		for (int k = 1; k < 32; k++)
			add_inst(enc_add(5'(k), 5'(k), 5'd0));
	endtask

	////////////////////
	// checking
	////////////////////
	task automatic check_field(input string name, input logic [31:0] got,
			input logic [31:0] exp, input logic [31:0] pc);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s at pc %h: got %h, expected %h", name, pc, got, exp);
		end
	endtask

	task automatic check_retire();
		ret_rec_t e;
		retired++;
		owed++;
		checks++;
		if (retired > `CORE_RETIRE_CREDITS + returned) begin
			errors++;
			$display("core retired more instructions than the credits it was granted");
		end
		if (exp_q.size() == 0) begin
			errors++;
			$display("unexpected retire with nothing outstanding, pc %h", ret_pc);
		end else begin
			e = exp_q.pop_front();
			check_field("ret_pc", ret_pc, e.pc, e.pc);
			check_field("ret_next_pc", ret_next_pc, e.next_pc, e.pc);
			check_field("ret_rd", 32'(ret_rd), 32'(e.rd), e.pc);
			check_field("ret_we", 32'(ret_we), 32'(e.we), e.pc);
			check_field("ret_halt", 32'(ret_halt), 32'(e.halt), e.pc);
			check_field("ret_illegal", 32'(ret_illegal), 32'(e.illegal), e.pc);
			if (e.we)
				check_field("ret_wdata", ret_wdata, e.wdata, e.pc);
		end
	endtask

	// one clock: sample outputs from before the edge, then drive the next inputs
	task automatic step();
		@(posedge clk);
		if (in_credit) begin
			prod_credits++;
			credit_pulses++;
		end
		if (ret_valid)
			check_retire();
		if (owed > 0 && (rnd() & 32'hff) < 32'(ret_thresh)) begin
			out_credit <= 1'b1;
			owed--;
			returned++;
		end else begin
			out_credit <= 1'b0;
		end
		if (prod_credits > 0 && pend_inst.size() > 0 && (rnd() & 32'hff) < 32'(push_thresh)) begin
			in_valid <= 1'b1;
			in_pc <= pend_pc.pop_front();
			in_inst <= pend_inst.pop_front();
			prod_credits--;
			pushes++;
		end else begin
			in_valid <= 1'b0;
		end
	endtask

	task automatic drain(input int limit, input string what);
		int n;
		n = 0;
		while ((pend_inst.size() != 0 || exp_q.size() != 0) && n < limit) begin
			step();
			n++;
		end
		if (pend_inst.size() != 0 || exp_q.size() != 0) begin
			$display("timeout after %0d cycles while %s", limit, what);
			$display("Test failed");
			$finish;
		end
	endtask

	task automatic do_reset();
		rst <= 1'b1;
		in_valid <= 1'b0;
		out_credit <= 1'b0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		pend_pc.delete();
		pend_inst.delete();
		exp_q.delete();
		for (int k = 0; k < 32; k++)
			mregs[k] = '0;
		prod_credits = `CORE_QUEUE_DEPTH;
		owed = 0;
		retired = 0;
		returned = 0;
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %0d %s done: %0d checks, %0d errors", tests, name,
			checks - check_mark, errors - err_mark);
		check_mark = checks;
		err_mark = errors;
	endtask

	////////////////////
	// test sequence
	////////////////////
	initial begin
		logic [31:0] r;
		rst = 1'b1;
		in_valid = 1'b0;
		in_pc = '0;
		in_inst = '0;
		out_credit = 1'b0;
		pc_gen = 32'h0000_1000;
		errors = 0;
		checks = 0;
		tests = 0;
		err_mark = 0;
		check_mark = 0;
		credit_pulses = 0;
		pushes = 0;
		push_thresh = 200;
		ret_thresh = 200;
		do_reset();

		// alu ops, registers seeded by lui first
		for (int i = 0; i < 8; i++) begin
			r = rnd();
			add_inst({r[31:12], 5'(i + 1), 7'h37});
		end
		for (int i = 0; i < 100; i++)
			add_inst(gen_alu());
		readback();
		drain(3000, "running alu instructions");
		end_test("alu");

		for (int i = 0; i < 60; i++)
			add_inst(gen_upper_jump());
		readback();
		drain(3000, "running upper and jump instructions");
		end_test("upper_jump");

		for (int i = 0; i < 80; i++)
			add_inst(gen_branch());
		drain(3000, "running branches");
		end_test("branch");

		// x0 as destination, then read back as a source
		for (int i = 0; i < 20; i++)
			add_inst(gen_alu() & 32'hffff_f07f);
		for (int k = 1; k < 9; k++) begin
			r = rnd();
			add_inst(enc_add(5'(k), 5'd0, 5'd0));
			add_inst({r[11:0], 5'd0, 3'b000, 5'(k + 8), 7'h13});
		end
		for (int i = 0; i < 10; i++) begin
			r = rnd();
			add_inst({r[31:7], 7'h03});
			r = rnd();
			add_inst({r[31:7], 7'h23});
		end
		readback();
		drain(3000, "running x0 and illegal instructions");
		end_test("x0_illegal");

		// heavy withholding of retire credits
		push_thresh = 100;
		ret_thresh = 30;
		credit_pulses = 0;
		pushes = 0;
		for (int i = 0; i < 60; i++) begin
			r = rnd();
			add_inst(r[0] ? gen_alu() : gen_branch());
		end
		drain(6000, "running under credit back-pressure");
		checks++;
		if (credit_pulses != pushes) begin
			errors++;
			$display("in_credit pulsed %0d times for %0d pushes", credit_pulses, pushes);
		end
		checks++;
		if (prod_credits != `CORE_QUEUE_DEPTH) begin
			errors++;
			$display("producer ended with %0d credits instead of a full set", prod_credits);
		end
		push_thresh = 200;
		ret_thresh = 200;
		end_test("credit_flow");

		// halt, then silence until reset
		for (int i = 0; i < 5; i++)
			add_inst(gen_alu());
		add_inst(32'h0010_0073);
		for (int i = 0; i < 3; i++)
			push_only(gen_alu());
		drain(1000, "waiting for the ebreak to retire");
		for (int i = 0; i < 40; i++)
			step();
		do_reset();
		for (int i = 0; i < 20; i++)
			add_inst(gen_alu());
		readback();
		drain(3000, "running instructions after reset");
		end_test("halt");

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* compile.f */
+incdir+design
design/core_pkg.sv
design/inst_queue.sv
design/idu.sv
design/gpr.sv
design/exu.sv
design/core_top.sv
tests/tb_core.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
verilator --binary --timing --assert -f compile.f --top-module tb_core &&
	./obj_dir/Vtb_core | tee /dev/stderr | grep -q "Test completed successfully" &&
	echo "PASS" ||
	{ echo "FAIL"; exit 1; }
